//--- compile.f
+incdir+logic
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_driver.sv
tb/uart_fifo_checker.sv
tb/uart_driver_tb.sv

//--- Makefile
TOP := uart_driver_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "Testbench passed" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- tb/uart_driver_tb.sv
`include "uart_consts.svh"

module uart_driver_tb
	import uart_pkg::*;
();

	localparam int CPB   = `UART_CLKS_PER_BIT;
	localparam int DEPTH = `UART_FIFO_DEPTH;

	// frames over all tests with the idle gap in the framing test counted as one
	localparam int FRAME_COUNT     = 1 + (DEPTH + 3) + 1 + 3 + (DEPTH + 1);
	localparam int WATCHDOG_CYCLES = FRAME_COUNT * 10 * CPB + 5000;
	localparam int WAIT_LIMIT      = 4 * CPB;

	logic       clk_in;
	logic       rst_n;
	logic       tx_trigger;
	uart_byte_t tx_data;
	logic       tx_ready;
	logic       rx_trigger;
	rx_frame_t  rx_data;
	logic       rx_ready;
	logic       tx;
	logic       rx;

	logic [31:0] lfsr_state = 32'hb780_05f9;

	int    errors;
	int    checks;
	int    tests_run;
	int    errors_at_start;
	string test_name;

	uart_driver u_uart_driver (
		.clk_in     (clk_in),
		.rst_n      (rst_n),
		.tx_trigger (tx_trigger),
		.tx_data    (tx_data),
		.tx_ready   (tx_ready),
		.rx_trigger (rx_trigger),
		.rx_data    (rx_data),
		.rx_ready   (rx_ready),
		.tx         (tx),
		.rx         (rx)
	);

	always #10 clk_in = ~clk_in;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < 8; i++) begin
			r = {r[6:0], lfsr_step()};
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %s expected 0x%0h got 0x%0h", name, expected, actual);
		end
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("ERROR %s", what);
	endtask

	task automatic start_test(input string name);
		test_name       = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	task automatic write_tx_byte(input logic [7:0] b);
		@(posedge clk_in);
		tx_trigger   <= 1'b1;
		tx_data.data <= b;
		@(posedge clk_in);
		tx_trigger <= 1'b0;
	endtask

	task automatic pop_rx();
		@(posedge clk_in);
		rx_trigger <= 1'b1;
		@(posedge clk_in);
		rx_trigger <= 1'b0;
	endtask

	// tx line model sampled at negedge where values are settled
	task automatic capture_tx_frame(output logic [7:0] data, output logic stop_bit,
		output int waited);
		data     = '0;
		stop_bit = 1'b0;
		waited   = 0;
		@(negedge clk_in);
		while (tx !== 1'b0 && waited < WAIT_LIMIT) begin
			@(negedge clk_in);
			waited++;
		end
		if (tx !== 1'b0) begin
			report_error("no start bit appeared on tx");
		end else begin
			repeat (CPB / 2) @(negedge clk_in);
			if (tx !== 1'b0) begin
				report_error("tx start bit ended before its middle");
			end
			for (int i = 0; i < 8; i++) begin
				repeat (CPB) @(negedge clk_in);
				data[i] = tx;
			end
			repeat (CPB) @(negedge clk_in);
			stop_bit = tx;
		end
	endtask

	// rx line model sends start bit, data lsb first and the chosen stop value
	task automatic send_rx_frame(input logic [7:0] b, input logic stop_val);
		logic [9:0] bits;
		bits = {stop_val, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk_in);
			rx <= bits[i];
			repeat (CPB - 1) @(posedge clk_in);
		end
		@(posedge clk_in);
		rx <= 1'b1;
	endtask

	task automatic wait_rx_ready();
		int waited;
		waited = 0;
		@(negedge clk_in);
		while (!rx_ready && waited < WAIT_LIMIT) begin
			@(negedge clk_in);
			waited++;
		end
		if (!rx_ready) begin
			report_error("rx_ready did not rise after a frame was sent");
		end
	endtask

	task automatic test_reset_state();
		start_test("reset_state");
		@(negedge clk_in);
		check_value("tx", 32'(1), 32'(tx));
		check_value("tx_ready", 32'(1), 32'(tx_ready));
		check_value("rx_ready", 32'(0), 32'(rx_ready));
		finish_test();
	endtask

	task automatic test_single_tx();
		logic [7:0] b;
		logic [7:0] got;
		logic       stop_bit;
		int         waited;
		start_test("single_transmit");
		b = random_byte();
		write_tx_byte(b);
		// one edge after the sampling edge the line is still idle
		@(posedge clk_in);
		@(negedge clk_in);
		check_value("tx", 32'(1), 32'(tx));
		capture_tx_frame(got, stop_bit, waited);
		check_value("tx start delay", 32'(0), 32'(waited));
		check_value("tx frame data", 32'(b), 32'(got));
		check_value("tx stop bit", 32'(1), 32'(stop_bit));
		finish_test();
	endtask

	task automatic test_tx_overflow();
		logic [7:0] kept[$];
		logic [7:0] b;
		logic [7:0] first_data;
		logic       first_stop;
		logic [7:0] got;
		logic       stop_bit;
		int         waited;
		int         low_seen;
		start_test("transmit_overflow");
		low_seen = 0;
		fork
			begin
				for (int k = 0; k < DEPTH + 3; k++) begin
					b = random_byte();
					@(posedge clk_in);
					tx_trigger   <= 1'b1;
					tx_data.data <= b;
					// tx_ready here is what the next edge samples
					@(negedge clk_in);
					if (tx_ready) begin
						kept.push_back(b);
					end else begin
						low_seen++;
					end
				end
				@(posedge clk_in);
				tx_trigger <= 1'b0;
			end
			begin
				// first frame may start while the burst is still running
				capture_tx_frame(first_data, first_stop, waited);
			end
		join
		if (kept.size() == 0) begin
			report_error("the transmit FIFO accepted no byte of the burst");
		end else begin
			check_value("tx frame data", 32'(kept[0]), 32'(first_data));
			check_value("tx stop bit", 32'(1), 32'(first_stop));
			for (int i = 1; i < kept.size(); i++) begin
				capture_tx_frame(got, stop_bit, waited);
				check_value("tx frame data", 32'(kept[i]), 32'(got));
				check_value("tx stop bit", 32'(1), 32'(stop_bit));
			end
		end
		if (low_seen == 0) begin
			report_error("tx_ready never went low during the burst");
		end
		finish_test();
	endtask

	task automatic test_single_rx();
		logic [7:0] b;
		start_test("single_receive");
		b = random_byte();
		send_rx_frame(b, 1'b1);
		wait_rx_ready();
		check_value("rx_data.data", 32'(b), 32'(rx_data.data));
		check_value("rx_data.frame_err", 32'(0), 32'(rx_data.frame_err));
		pop_rx();
		@(negedge clk_in);
		check_value("rx_ready", 32'(0), 32'(rx_ready));
		// a pop with nothing stored has no effect
		pop_rx();
		@(negedge clk_in);
		check_value("rx_ready", 32'(0), 32'(rx_ready));
		finish_test();
	endtask

	task automatic test_framing_error();
		logic [7:0] b;
		start_test("framing_error");
		b = random_byte();
		send_rx_frame(b, 1'b0);
		wait_rx_ready();
		check_value("rx_data.data", 32'(b), 32'(rx_data.data));
		check_value("rx_data.frame_err", 32'(1), 32'(rx_data.frame_err));
		pop_rx();
		// one idle bit time before the clean frame
		repeat (CPB) @(posedge clk_in);
		b = random_byte();
		send_rx_frame(b, 1'b1);
		wait_rx_ready();
		check_value("rx_data.data", 32'(b), 32'(rx_data.data));
		check_value("rx_data.frame_err", 32'(0), 32'(rx_data.frame_err));
		pop_rx();
		@(negedge clk_in);
		check_value("rx_ready", 32'(0), 32'(rx_ready));
		finish_test();
	endtask

	task automatic test_rx_overflow();
		logic [7:0] sent[$];
		logic [7:0] b;
		start_test("receive_overflow");
		for (int k = 0; k < DEPTH + 1; k++) begin
			b = random_byte();
			sent.push_back(b);
			send_rx_frame(b, 1'b1);
		end
		// the last frame found the FIFO full
		for (int k = 0; k < DEPTH; k++) begin
			wait_rx_ready();
			check_value("rx_data.data", 32'(sent[k]), 32'(rx_data.data));
			check_value("rx_data.frame_err", 32'(0), 32'(rx_data.frame_err));
			pop_rx();
		end
		@(negedge clk_in);
		check_value("rx_ready", 32'(0), 32'(rx_ready));
		finish_test();
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_in);
		$display("timeout: tests still running after %0d clock cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		clk_in     = 1'b0;
		rst_n      = 1'b0;
		tx_trigger = 1'b0;
		tx_data    = '0;
		rx_trigger = 1'b0;
		rx         = 1'b1;
		errors     = 0;
		checks     = 0;
		tests_run  = 0;
		repeat (3) @(posedge clk_in);
		rst_n <= 1'b1;

		test_reset_state();
		test_single_tx();
		test_tx_overflow();
		test_single_rx();
		test_framing_error();
		test_rx_overflow();

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- tb/uart_fifo_checker.sv
module uart_fifo_checker (
	input logic clk_in,
	input logic rst_n,
	input logic push,
	input logic pop,
	input logic empty,
	input logic full
);

	// a push into an empty FIFO always lands, a same-cycle pop cannot take it
	a_push_when_empty: assert property (
		@(posedge clk_in) disable iff (!rst_n)
		(push && empty) |=> !empty
	) else $error("fifo stayed empty after a push into an empty fifo");

	// an extra push into a full FIFO is dropped
	a_push_when_full: assert property (
		@(posedge clk_in) disable iff (!rst_n)
		(push && full && !pop) |=> full
	) else $error("fifo left full state on a push without pop");

	// popping an empty FIFO must not underflow the counter
	a_pop_when_empty: assert property (
		@(posedge clk_in) disable iff (!rst_n)
		(pop && empty && !push) |=> empty
	) else $error("fifo left empty state on a pop without push");

endmodule

bind uart_fifo uart_fifo_checker u_fifo_checker (
	.clk_in (clk_in),
	.rst_n  (rst_n),
	.push   (push),
	.pop    (pop),
	.empty  (empty),
	.full   (full)
);

//--- logic/uart_driver.sv
`include "uart_consts.svh"

module uart_driver
	import uart_pkg::*;
(
	input  logic       clk_in,
	input  logic       rst_n,

	// user transmit side
	input  logic       tx_trigger,
	input  uart_byte_t tx_data,
	output logic       tx_ready,

	// user receive side
	input  logic       rx_trigger,
	output rx_frame_t  rx_data,
	output logic       rx_ready,

	// serial line
	output logic       tx,
	input  logic       rx
);

	logic       tx_push;
	logic       tx_pop;
	logic       tx_fifo_empty;
	logic       tx_fifo_full;
	uart_byte_t tx_head;

	logic       rx_push;
	logic       rx_fifo_empty;
	rx_frame_t  rx_frame;

	// a trigger without room is dropped here
	assign tx_push  = tx_trigger && tx_ready;
	assign tx_ready = !tx_fifo_full;
	assign rx_ready = !rx_fifo_empty;

	uart_fifo #(
		.payload_t (uart_byte_t),
		.DEPTH     (`UART_FIFO_DEPTH)
	) u_tx_fifo (
		.clk_in    (clk_in),
		.rst_n     (rst_n),
		.push      (tx_push),
		.push_data (tx_data),
		.pop       (tx_pop),
		.head      (tx_head),
		.empty     (tx_fifo_empty),
		.full      (tx_fifo_full)
	);

	uart_tx u_tx (
		.clk_in     (clk_in),
		.rst_n      (rst_n),
		.byte_avail (!tx_fifo_empty),
		.byte_in    (tx_head),
		.byte_pop   (tx_pop),
		.tx         (tx)
	);

	uart_rx u_rx (
		.clk_in     (clk_in),
		.rst_n      (rst_n),
		.rx         (rx),
		.frame_push (rx_push),
		.frame      (rx_frame)
	);

	// full rx FIFO drops the new frame inside the FIFO itself
	uart_fifo #(
		.payload_t (rx_frame_t),
		.DEPTH     (`UART_FIFO_DEPTH)
	) u_rx_fifo (
		.clk_in    (clk_in),
		.rst_n     (rst_n),
		.push      (rx_push),
		.push_data (rx_frame),
		.pop       (rx_trigger),
		.head      (rx_data),
		.empty     (rx_fifo_empty),
		.full      ()
	);

endmodule

//--- logic/uart_rx.sv
`include "uart_consts.svh"

module uart_rx
	import uart_pkg::*;
(
	input  logic      clk_in,
	input  logic      rst_n,
	input  logic      rx,
	output logic      frame_push,
	output rx_frame_t frame
);

	localparam logic [`UART_CNT_W-1:0] BIT_LAST  = `UART_CNT_W'(`UART_CLKS_PER_BIT - 1);
	localparam logic [`UART_CNT_W-1:0] HALF_LAST = `UART_CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;

	logic rx_meta;
	logic rx_sync;
	logic rx_prev;

	logic [`UART_CNT_W-1:0] cnt;
	logic [2:0]             bit_idx;
	logic [7:0]             data_sr;

	logic sample;

	// once aligned to mid start bit, every full period lands mid-bit
	assign sample = (cnt == BIT_LAST);

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			rx_meta    <= 1'b1;
			rx_sync    <= 1'b1;
			rx_prev    <= 1'b1;
			state      <= RX_IDLE;
			cnt        <= '0;
			bit_idx    <= '0;
			frame_push <= 1'b0;
		end else begin
			// two-flop synchronizer, then one more for edge detect
			rx_meta    <= rx;
			rx_sync    <= rx_meta;
			rx_prev    <= rx_sync;
			frame_push <= 1'b0;

			case (state)
				RX_IDLE: begin
					// falling edge only, a line stuck low does not retrigger
					if (rx_prev && !rx_sync) begin
						state <= RX_START;
						cnt   <= '0;
					end
				end
				RX_START: begin
					if (cnt == HALF_LAST) begin
						cnt     <= '0;
						bit_idx <= '0;
						// high again at mid start means a glitch
						state   <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (sample) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (sample) begin
						cnt        <= '0;
						frame_push <= 1'b1;
						state      <= RX_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// data path, lsb arrives first
	always_ff @(posedge clk_in) begin
		if (state == RX_DATA && sample) begin
			data_sr <= {rx_sync, data_sr[7:1]};
		end
		if (state == RX_STOP && sample) begin
			frame.data      <= data_sr;
			frame.frame_err <= !rx_sync;
		end
	end

endmodule

//--- logic/uart_tx.sv
`include "uart_consts.svh"

module uart_tx
	import uart_pkg::*;
(
	input  logic       clk_in,
	input  logic       rst_n,
	input  logic       byte_avail,
	input  uart_byte_t byte_in,
	output logic       byte_pop,
	output logic       tx
);

	localparam logic [`UART_CNT_W-1:0] BIT_LAST = `UART_CNT_W'(`UART_CLKS_PER_BIT - 1);

	logic                   busy;
	logic [`UART_CNT_W-1:0] cnt;
	logic [3:0]             bit_idx;
	logic [9:0]             frame_sr;

	logic bit_end;
	logic frame_end;

	assign bit_end   = (cnt == BIT_LAST);
	assign frame_end = busy && bit_end && (bit_idx == 4'd9);

	// take the next byte when idle, or on the very last cycle of a stop bit
	// so back-to-back frames run without a gap
	assign byte_pop = byte_avail && (!busy || frame_end);

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			cnt     <= '0;
			bit_idx <= '0;
			tx      <= 1'b1;
		end else begin
			// line register, one cycle behind the shifter
			tx <= busy ? frame_sr[0] : 1'b1;

			if (byte_pop) begin
				busy    <= 1'b1;
				cnt     <= '0;
				bit_idx <= '0;
			end else if (frame_end) begin
				busy    <= 1'b0;
				cnt     <= '0;
				bit_idx <= '0;
			end else if (busy) begin
				if (bit_end) begin
					cnt     <= '0;
					bit_idx <= bit_idx + 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// frame shifter, bit 0 is the bit on the line next
	always_ff @(posedge clk_in) begin
		if (byte_pop) begin
			// stop, data lsb first, start
			frame_sr <= {1'b1, byte_in.data, 1'b0};
		end else if (busy && bit_end) begin
			frame_sr <= {1'b1, frame_sr[9:1]};
		end
	end

endmodule

//--- logic/uart_fifo.sv
`include "uart_consts.svh"

module uart_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = `UART_FIFO_DEPTH
) (
	input  logic     clk_in,
	input  logic     rst_n,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t head,
	output logic     empty,
	output logic     full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic push_ok;
	logic pop_ok;

	// a push into a full FIFO is simply lost
	assign push_ok = push && !full;
	assign pop_ok  = pop && !empty;

	assign empty = (count == '0);
	assign full  = (count == CNT_FULL);

	// show-ahead, oldest entry always on the head
	assign head = mem[rd_ptr];

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			end
			// occupancy only moves when exactly one side acts
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage
	always_ff @(posedge clk_in) begin
		if (push_ok) begin
			mem[wr_ptr] <= push_data;
		end
	end

endmodule

//--- logic/uart_pkg.sv
package uart_pkg;

	// one byte queued for transmission
	typedef struct packed {
		logic [7:0] data;
	} uart_byte_t;

	// one received frame as stored in the rx FIFO
	// frame_err is set when the stop bit was sampled low,
	// data still holds whatever bits were on the line
	typedef struct packed {
		logic [7:0] data;
		logic       frame_err;
	} rx_frame_t;

endpackage

//--- logic/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// system clock feeding clk_in
`define UART_CLK_HZ 24000000

// fixed line rate, 8N1 only
`define UART_BAUD 115200

// clocks per serial bit, 208 at 24 MHz
`define UART_CLKS_PER_BIT (`UART_CLK_HZ / `UART_BAUD)

// entries in each direction's FIFO
`define UART_FIFO_DEPTH 8

// bit-period counter width
// must hold UART_CLKS_PER_BIT - 1
`define UART_CNT_W 16

`endif
